/* rtl/lcdPkg.sv */
`default_nettype none

package lcdPkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] coord_t;
  typedef logic [15:0] rgb565_t;

  // inclusive pixel bounds
  typedef struct packed {
    coord_t xStart;
    coord_t xEnd;
    coord_t yStart;
    coord_t yEnd;
  } window_t;

  typedef enum logic [1:0] {
    opInit,
    opDispOn,
    opDispOff,
    opFill
  } lcdOp_t;

  // panel command set
  typedef enum logic [7:0] {
    cmdSwReset     = 8'h01,
    cmdSleepIn     = 8'h10,
    cmdSleepOut    = 8'h11,
    cmdDispOff     = 8'h28,
    cmdDispOn      = 8'h29,
    cmdColumnAddr  = 8'h2A,
    cmdPageAddr    = 8'h2B,
    cmdMemWrite    = 8'h2C,
    cmdMemAccess   = 8'h36,
    cmdPixelFormat = 8'h3A
  } lcdCmd_t;

  typedef enum logic [1:0] {
    itemCmd,
    itemParam,
    itemDelay,   // value in ms
    itemRelease
  } itemKind_t;

  typedef struct packed {
    itemKind_t kind;
    byte_t     value;
  } busItem_t;

  localparam byte_t PixelFormatRgb565 = 8'h55;
  localparam byte_t MemAccessDefault  = 8'h30;  // orientation

  localparam byte_t resetDelayMs    = 8'd5;
  localparam byte_t sleepOutDelayMs = 8'd120;
  localparam byte_t dispOnDelayMs   = 8'd5;
  localparam byte_t dispOffDelayMs  = 8'd10;
  localparam byte_t sleepInDelayMs  = 8'd10;

  localparam int FifoDepth = 8;
  localparam int FifoPtrW  = $clog2(FifoDepth);

  function automatic busItem_t mkItem(itemKind_t kind, byte_t value);
    busItem_t it;
    it.kind  = kind;
    it.value = value;
    return it;
  endfunction

endpackage

`default_nettype wire

/* rtl/opSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module opSequencer (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  start,
  input  wire lcdPkg::lcdOp_t  op,
  input  wire lcdPkg::window_t window,
  input  wire lcdPkg::rgb565_t color,
  input  wire                  full,
  output logic                 push,
  output lcdPkg::busItem_t     item
);
  import lcdPkg::*;

  typedef enum logic [2:0] {
    sIdle,
    sHeader,
    sAddrX,
    sAddrY,
    sPixels,
    sRelease
  } seqState_t;

  seqState_t   state;
  logic [3:0]  step;
  logic [3:0]  headerLast;
  logic [31:0] pixelsLeft;
  logic [16:0] width;
  logic [16:0] height;
  logic [33:0] area;
  lcdOp_t      opReg;
  window_t     win;
  rgb565_t     colorReg;

  // fixed item lists for the non-fill ops
  function automatic busItem_t headerItem(lcdOp_t o, logic [3:0] s);
    busItem_t it;
    it = mkItem(itemRelease, 8'h00);
    case (o)
      opInit: begin
        case (s)
          4'd0: it = mkItem(itemCmd, cmdSwReset);
          4'd1: it = mkItem(itemDelay, resetDelayMs);
          4'd2: it = mkItem(itemCmd, cmdSleepOut);
          4'd3: it = mkItem(itemDelay, sleepOutDelayMs);
          4'd4: it = mkItem(itemCmd, cmdPixelFormat);
          4'd5: it = mkItem(itemParam, PixelFormatRgb565);
          4'd6: it = mkItem(itemCmd, cmdMemAccess);
          4'd7: it = mkItem(itemParam, MemAccessDefault);
          default: it = mkItem(itemCmd, cmdDispOn);
        endcase
      end
      opDispOn: begin
        case (s)
          4'd0: it = mkItem(itemCmd, cmdSleepOut);
          4'd1: it = mkItem(itemDelay, sleepOutDelayMs);
          4'd2: it = mkItem(itemCmd, cmdDispOn);
          default: it = mkItem(itemDelay, dispOnDelayMs);
        endcase
      end
      opDispOff: begin
        case (s)
          4'd0: it = mkItem(itemCmd, cmdDispOff);
          4'd1: it = mkItem(itemDelay, dispOffDelayMs);
          4'd2: it = mkItem(itemCmd, cmdSleepIn);
          default: it = mkItem(itemDelay, sleepInDelayMs);
        endcase
      end
      default: it = mkItem(itemRelease, 8'h00);
    endcase
    return it;
  endfunction

  // cmd then start hi/lo, end hi/lo
  function automatic busItem_t addrItem(lcdCmd_t c, coord_t lo, coord_t hi, logic [3:0] s);
    busItem_t it;
    case (s)
      4'd0: it = mkItem(itemCmd, c);
      4'd1: it = mkItem(itemParam, lo[15:8]);
      4'd2: it = mkItem(itemParam, lo[7:0]);
      4'd3: it = mkItem(itemParam, hi[15:8]);
      default: it = mkItem(itemParam, hi[7:0]);
    endcase
    return it;
  endfunction

  assign headerLast = (opReg == opInit) ? 4'd8 : 4'd3;
  assign width      = {1'b0, win.xEnd} - {1'b0, win.xStart} + 17'd1;
  assign height     = {1'b0, win.yEnd} - {1'b0, win.yStart} + 17'd1;
  assign area       = width * height;
  assign push       = (state != sIdle) && !full;  // stall on full

  always_comb begin
    case (state)
      sHeader: item = headerItem(opReg, step);
      sAddrX:  item = addrItem(cmdColumnAddr, win.xStart, win.xEnd, step);
      sAddrY:  item = addrItem(cmdPageAddr, win.yStart, win.yEnd, step);
      sPixels: begin
        if (step == 4'd0)
          item = mkItem(itemCmd, cmdMemWrite);
        else if (step == 4'd1)
          item = mkItem(itemParam, colorReg[15:8]);
        else
          item = mkItem(itemParam, colorReg[7:0]);
      end
      default: item = mkItem(itemRelease, 8'h00);
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == sIdle && start) begin
      opReg    <= op;
      win      <= window;
      colorReg <= color;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= sIdle;
      step       <= '0;
      pixelsLeft <= '0;
    end else begin
      case (state)
        sIdle: begin
          if (start) begin
            state <= (op == opFill) ? sAddrX : sHeader;
            step  <= '0;
          end
        end
        sHeader: begin
          if (push) begin
            step  <= (step == headerLast) ? 4'd0 : step + 4'd1;
            state <= (step == headerLast) ? sRelease : sHeader;
          end
        end
        sAddrX: begin
          if (push) begin
            step  <= (step == 4'd4) ? 4'd0 : step + 4'd1;
            state <= (step == 4'd4) ? sAddrY : sAddrX;
          end
        end
        sAddrY: begin
          if (push && step == 4'd4) begin
            state      <= sPixels;
            step       <= '0;
            pixelsLeft <= area[31:0];
          end else if (push) begin
            step <= step + 4'd1;
          end
        end
        sPixels: begin
          if (push) begin
            if (step != 4'd2) begin
              step <= step + 4'd1;
            end else if (pixelsLeft <= 32'd1) begin
              state <= sRelease;  // last low byte out
            end else begin
              step       <= 4'd1;
              pixelsLeft <= pixelsLeft - 32'd1;
            end
          end
        end
        default: begin
          if (push)
            state <= sIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/itemFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module itemFifo (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   push,
  input  wire lcdPkg::busItem_t pushItem,
  input  wire                   pop,
  output lcdPkg::busItem_t      popItem,
  output logic                  full,
  output logic                  empty
);
  import lcdPkg::*;

  busItem_t            mem [FifoDepth];
  logic [FifoPtrW-1:0] wrPtr;
  logic [FifoPtrW-1:0] rdPtr;
  logic [FifoPtrW:0]   count;
  logic                doPush;
  logic                doPop;

  assign doPush  = push && !full;
  assign doPop   = pop && !empty;
  assign full    = (count == (FifoPtrW + 1)'(FifoDepth));
  assign empty   = (count == '0);
  assign popItem = mem[rdPtr];  // head is visible the cycle after push

  always_ff @(posedge clk) begin
    if (doPush)
      mem[wrPtr] <= pushItem;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;  // power-of-two depth wraps
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/busWriter.sv */
`timescale 1ns/1ns
`default_nettype none

module busWriter #(
  parameter int MsCycles = 100000
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   empty,
  output logic                  pop,
  input  wire lcdPkg::busItem_t item,
  output logic                  csx,
  output logic                  dcx,
  output logic                  wrx,
  output lcdPkg::byte_t         data,
  output logic                  done
);
  import lcdPkg::*;

  typedef enum logic [2:0] {
    wIdle,
    wSelect,
    wStrobeLow,
    wStrobeHigh,
    wWaiting,
    wDeselect,
    wFinish
  } wrState_t;

  wrState_t    state;
  busItem_t    held;
  logic [31:0] delayCnt;
  logic [31:0] delayLoad;
  logic        ready;

  // strobeHigh doubles as idle so bytes go out every 2 cycles
  assign ready     = (state == wIdle) || (state == wStrobeHigh);
  assign pop       = ready && !empty;
  assign delayLoad = 32'(item.value) * 32'(MsCycles);

  always_ff @(posedge clk) begin
    if (pop)
      held <= item;  // needed after the select cycle
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= wIdle;
      csx      <= 1'b1;
      dcx      <= 1'b1;
      wrx      <= 1'b1;
      data     <= '0;
      done     <= 1'b0;
      delayCnt <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        wIdle, wStrobeHigh: begin
          if (!pop) begin
            state <= wIdle;  // hold pins
          end else begin
            case (item.kind)
              itemCmd, itemParam: begin
                if (csx) begin
                  csx   <= 1'b0;
                  state <= wSelect;
                end else begin
                  wrx   <= 1'b0;
                  dcx   <= (item.kind == itemParam);
                  data  <= item.value;
                  state <= wStrobeLow;
                end
              end
              itemDelay: begin
                delayCnt <= delayLoad;
                state    <= (delayLoad == '0) ? wIdle : wWaiting;
              end
              default: begin
                csx   <= 1'b1;
                state <= wDeselect;
              end
            endcase
          end
        end
        wSelect: begin
          wrx   <= 1'b0;
          dcx   <= (held.kind == itemParam);
          data  <= held.value;
          state <= wStrobeLow;
        end
        wStrobeLow: begin
          wrx   <= 1'b1;  // panel latches here
          state <= wStrobeHigh;
        end
        wWaiting: begin
          if (delayCnt == 32'd1)
            state <= wIdle;
          else
            delayCnt <= delayCnt - 32'd1;
        end
        wDeselect: begin
          done  <= 1'b1;
          state <= wFinish;
        end
        default: state <= wIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/lcdController.sv */
`timescale 1ns/1ns
`default_nettype none

module lcdController #(
  parameter int MsCycles = 100000
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  start,
  input  wire lcdPkg::lcdOp_t  op,
  input  wire lcdPkg::window_t window,
  input  wire lcdPkg::rgb565_t color,
  output logic                 csx,
  output logic                 dcx,
  output logic                 wrx,
  output lcdPkg::byte_t        data,
  output logic                 done
);
  import lcdPkg::*;

  busItem_t seqItem;
  busItem_t headItem;
  logic     seqPush;
  logic     fifoFull;
  logic     fifoEmpty;
  logic     wrPop;

  opSequencer u_opSequencer (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .window (window),
    .color  (color),
    .full   (fifoFull),
    .push   (seqPush),
    .item   (seqItem)
  );

  itemFifo u_itemFifo (
    .clk      (clk),
    .rst      (rst),
    .push     (seqPush),
    .pushItem (seqItem),
    .pop      (wrPop),
    .popItem  (headItem),
    .full     (fifoFull),
    .empty    (fifoEmpty)
  );

  busWriter #(
    .MsCycles (MsCycles)
  ) u_busWriter (
    .clk   (clk),
    .rst   (rst),
    .empty (fifoEmpty),
    .pop   (wrPop),
    .item  (headItem),
    .csx   (csx),
    .dcx   (dcx),
    .wrx   (wrx),
    .data  (data),
    .done  (done)
  );

endmodule

`default_nettype wire

/* sim/lcdController_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module lcdController_chk (
  input wire                clk,
  input wire                rst,
  input wire                csx,
  input wire                dcx,
  input wire                wrx,
  input wire lcdPkg::byte_t data,
  input wire                done
);

  // strobe only inside a selected frame
  strobeInFrame: assert property (@(posedge clk) disable iff (rst) !wrx |-> !csx)
    else $error("wrx low while csx high");

  donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high for two cycles in a row");

  busStable: assert property (@(posedge clk) disable iff (rst)
    (wrx && $past(wrx)) |-> ($stable(dcx) && $stable(data)))  // only moves with wrx low
    else $error("dcx or data changed while wrx high");

endmodule

bind lcdController lcdController_chk u_lcdController_chk (
  .clk  (clk),
  .rst  (rst),
  .csx  (csx),
  .dcx  (dcx),
  .wrx  (wrx),
  .data (data),
  .done (done)
);

`default_nettype wire

/* sim/tb_lcdController.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lcdController;
  import lcdPkg::*;

  localparam int     MsCycles  = 4;
  localparam longint ClkPeriod = 8;
  localparam int     DelayTag  = 32'h10000;  // delay entries hold this tag plus ms

  logic    clk = 1'b0;
  logic    rst;
  logic    start;
  lcdOp_t  op;
  window_t window;
  rgb565_t color;
  logic    csx;
  logic    dcx;
  logic    wrx;
  byte_t   data;
  logic    done;

  integer     seed;
  int         errCount = 0;
  int         testCount = 0;
  int         doneCount = 0;
  int         budgetCycles = 0;
  string      curTest = "reset";
  int         expQ[$];  // {dcx, data} per byte
  logic [8:0] gotQ[$];
  longint     gotTime[$];
  longint     lastEdge = 0;
  logic       haveEdge = 1'b0;
  int         pendingMs = 0;
  logic       prevCsx = 1'b1;

  string   tName[$];
  lcdOp_t  tOp[$];
  window_t tWin[$];
  rgb565_t tColor[$];

  lcdController #(
    .MsCycles (MsCycles)
  ) u_lcdController (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .window (window),
    .color  (color),
    .csx    (csx),
    .dcx    (dcx),
    .wrx    (wrx),
    .data   (data),
    .done   (done)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic checkValue(string what, logic [31:0] expVal, logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("error %s %s: expected %0h, actual %0h", curTest, what, expVal, actVal);
      errCount++;
    end
  endtask

  function automatic void expectByte(logic isParam, byte_t b);
    expQ.push_back(int'({isParam, b}));
  endfunction

  function automatic void expectDelay(int ms);
    expQ.push_back(DelayTag + ms);
  endfunction

  // reference stream per op from the command table
  function automatic void buildExpected(lcdOp_t o, window_t w, rgb565_t c);
    int pixels;
    pixels = (int'(w.xEnd) - int'(w.xStart) + 1) * (int'(w.yEnd) - int'(w.yStart) + 1);
    case (o)
      opInit: begin
        expectByte(1'b0, 8'h01);
        expectDelay(5);
        expectByte(1'b0, 8'h11);
        expectDelay(120);
        expectByte(1'b0, 8'h3A);
        expectByte(1'b1, 8'h55);
        expectByte(1'b0, 8'h36);
        expectByte(1'b1, 8'h30);
        expectByte(1'b0, 8'h29);
      end
      opDispOn: begin
        expectByte(1'b0, 8'h11);
        expectDelay(120);
        expectByte(1'b0, 8'h29);
        expectDelay(5);
      end
      opDispOff: begin
        expectByte(1'b0, 8'h28);
        expectDelay(10);
        expectByte(1'b0, 8'h10);
        expectDelay(10);
      end
      default: begin
        expectByte(1'b0, 8'h2A);
        expectByte(1'b1, w.xStart[15:8]);
        expectByte(1'b1, w.xStart[7:0]);
        expectByte(1'b1, w.xEnd[15:8]);
        expectByte(1'b1, w.xEnd[7:0]);
        expectByte(1'b0, 8'h2B);
        expectByte(1'b1, w.yStart[15:8]);
        expectByte(1'b1, w.yStart[7:0]);
        expectByte(1'b1, w.yEnd[15:8]);
        expectByte(1'b1, w.yEnd[7:0]);
        expectByte(1'b0, 8'h2C);
        for (int i = 0; i < pixels; i++) begin
          expectByte(1'b1, c[15:8]);  // high byte first
          expectByte(1'b1, c[7:0]);
        end
      end
    endcase
  endfunction

  function automatic int bytesLeft();
    int n;
    n = 0;
    foreach (expQ[k]) begin
      if (expQ[k] < DelayTag)
        n++;
    end
    return n;
  endfunction

  function automatic window_t makeWindow(int xs, int xe, int ys, int ye);
    window_t w;
    w.xStart = coord_t'(xs);
    w.xEnd   = coord_t'(xe);
    w.yStart = coord_t'(ys);
    w.yEnd   = coord_t'(ye);
    return w;
  endfunction

  function automatic window_t randomWindow(int maxSide);
    window_t w;
    w.xStart = coord_t'({$random(seed)} % 32'd200);
    w.xEnd   = w.xStart + coord_t'({$random(seed)} % maxSide);
    w.yStart = coord_t'({$random(seed)} % 32'd300);
    w.yEnd   = w.yStart + coord_t'({$random(seed)} % maxSide);
    return w;
  endfunction

  function automatic void addTest(string name, lcdOp_t o, window_t w, rgb565_t c);
    tName.push_back(name);
    tOp.push_back(o);
    tWin.push_back(w);
    tColor.push_back(c);
  endfunction

  // byte monitor on the rising strobe where the panel latches
  always @(posedge wrx) begin
    if (!rst) begin
      gotQ.push_back({dcx, data});
      gotTime.push_back($time);
    end
  end

  always @(negedge clk) begin
    longint t;
    int     gap;
    while (expQ.size() > 0 && expQ[0] >= DelayTag)
      pendingMs += expQ.pop_front() - DelayTag;
    if (gotQ.size() > 0) begin
      t = gotTime.pop_front();
      if (expQ.size() == 0) begin
        $display("error %s: byte %0h appeared on the bus but none was expected",
                 curTest, gotQ.pop_front());
        errCount++;
      end else begin
        checkValue("byte", expQ.pop_front(), 32'(gotQ.pop_front()));
        gap = int'((t - lastEdge) / ClkPeriod);
        if (haveEdge && gap < pendingMs * MsCycles) begin
          $display("error %s delay gap: expected at least %0d cycles, actual %0d",
                   curTest, pendingMs * MsCycles, gap);
          errCount++;
        end
      end
      pendingMs = 0;
      lastEdge  = t;
      haveEdge  = 1'b1;
    end
    if (!rst && csx && !prevCsx && bytesLeft() != 0) begin
      $display("error %s: chip select went high with %0d bytes still to send",
               curTest, bytesLeft());
      errCount++;
    end
    prevCsx = csx;
    if (!rst && done)
      doneCount++;
  end

  task automatic runOp(string name, lcdOp_t o, window_t w, rgb565_t c);
    int errBefore;
    int dBefore;
    errBefore = errCount;
    dBefore   = doneCount;
    curTest   = name;
    buildExpected(o, w, c);
    @(posedge clk);
    start  <= 1'b1;
    op     <= o;
    window <= w;
    color  <= c;
    @(posedge clk);
    start <= 1'b0;
    while (doneCount == dBefore)
      @(negedge clk);
    repeat (4) @(negedge clk);  // let the compare drain
    checkValue("done pulses", 32'd1, 32'(doneCount - dBefore));
    if (expQ.size() != 0) begin
      $display("error %s: %0d expected bytes never reached the bus", name, bytesLeft());
      errCount++;
      expQ.delete();
    end
    testCount++;
    $display("test %s finished with %0d errors", name, errCount - errBefore);
  endtask

  initial begin
    seed = 70;
    rst    <= 1'b1;
    start  <= 1'b0;
    op     <= opInit;
    window <= '0;
    color  <= '0;

    addTest("init", opInit, '0, '0);
    addTest("dispOn", opDispOn, '0, '0);
    addTest("dispOff", opDispOff, '0, '0);
    for (int i = 0; i < 4; i++)
      addTest($sformatf("fill%0d", i), opFill, randomWindow(4), rgb565_t'($random(seed)));
    addTest("fillLarge", opFill, makeWindow(10, 17, 20, 25), rgb565_t'($random(seed)));
    addTest("dispOffAfterFill", opDispOff, '0, '0);
    addTest("initAgain", opInit, '0, '0);

    // watchdog budget from the reference streams
    foreach (tOp[i])
      buildExpected(tOp[i], tWin[i], tColor[i]);
    foreach (expQ[k])
      budgetCycles += (expQ[k] >= DelayTag) ? (expQ[k] - DelayTag) * MsCycles : 40;
    budgetCycles += 300 + 20 * tOp.size();
    expQ.delete();

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (10) begin
      @(negedge clk);
      checkValue("idle pins", 32'h0E00, 32'({csx, wrx, dcx, done, data}));
    end
    testCount++;
    $display("test reset finished with %0d errors", errCount);

    foreach (tOp[i])
      runOp(tName[i], tOp[i], tWin[i], tColor[i]);

    $display("tests %0d, errors %0d", testCount, errCount);
    if (errCount == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial begin
    wait (budgetCycles != 0);
    repeat (budgetCycles) @(posedge clk);
    $display("timeout in test %s: no done after %0d cycles", curTest, budgetCycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/lcdPkg.sv
rtl/opSequencer.sv
rtl/itemFifo.sv
rtl/busWriter.sv
rtl/lcdController.sv
sim/lcdController_chk.sv
sim/tb_lcdController.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcdController
FLIST     ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
